// ==== mdec_pkg.sv ====
package mdec_pkg;

	// ------------------------------------------------------------------
	// Widths fixed by the MDEC stream format
	// ------------------------------------------------------------------
	localparam int COEF_W  = 20;
	localparam int LEVEL_W = 10;
	localparam int QUANT_W = 7;

	// End of block, also used as padding between blocks
	localparam logic [15:0] END_OF_BLOCK = 16'hFE00;

	// Block number reported for every block in Y-only mode
	localparam logic [2:0] BLK_Y_ONLY = 3'd7;

	// First word of a block
	typedef struct packed {
		logic [5:0]                quantScale;
		logic signed [LEVEL_W-1:0] dcLevel;
	} dcHdr_t;

	// Every later word of a block
	typedef struct packed {
		logic [5:0]                run;
		logic signed [LEVEL_W-1:0] acLevel;
	} acCode_t;

	// One stream word, meaning depends on its position in the block
	typedef union packed {
		dcHdr_t  dcHdr;
		acCode_t acCode;
	} rleWord_t;

	// Zigzag position to row-major index, standard JPEG order
	localparam logic [5:0] ZAG_TO_LIN [64] = '{
		 0,  1,  8, 16,  9,  2,  3, 10,
		17, 24, 32, 25, 18, 11,  4,  5,
		12, 19, 26, 33, 40, 48, 41, 34,
		27, 20, 13,  6,  7, 14, 21, 28,
		35, 42, 49, 56, 57, 50, 43, 36,
		29, 22, 15, 23, 30, 37, 44, 51,
		58, 59, 52, 45, 38, 31, 39, 46,
		53, 60, 61, 54, 47, 55, 62, 63
	};

	function automatic logic [5:0] zagToLinear(input logic [5:0] zagPos);
		return ZAG_TO_LIN[zagPos];
	endfunction

endpackage

// ==== coefBus.sv ====
`timescale 1ns/1ps

interface coefBus;
	import mdec_pkg::*;

	// Strobes, one cycle each, never together
	logic                      wrt;
	logic                      complete;

	// Coefficient fields, valid with wrt
	logic                      isDC;
	logic [5:0]                zagIdx;
	// Storage order for the IDCT side
	logic [5:0]                linIdx;
	logic signed [LEVEL_W-1:0] level;
	logic [5:0]                scale;

	// Valid with wrt and with complete
	logic [2:0]                blkNum;

	// Stream decoder side
	modport src (
		output wrt, complete, isDC, zagIdx, linIdx, level, scale, blkNum
	);

	// Dequantizer side
	modport dst (
		input wrt, complete, isDC, zagIdx, linIdx, level, scale, blkNum
	);

endinterface

// ==== mdecStreamDecoder.sv ====
`timescale 1ns/1ps

module mdecStreamDecoder (
	input                     clk,
	input                     i_rst,
	input                     i_dataWrite,
	input mdec_pkg::rleWord_t i_dataIn,
	input                     i_yOnly,
	coefBus.src               o_bus
);
	import mdec_pkg::*;

	// ------------------------------------------------------------------
	// Block state
	// ------------------------------------------------------------------
	// Low while waiting for a DC header
	logic       inAc;
	// Zigzag position of the last emitted coefficient
	logic [5:0] zagPos;
	// Color mode block counter, 0..5
	logic [2:0] blkCnt;
	// Number of the block being decoded
	logic [2:0] curBlk;
	// Scale from the DC header, held for the whole block
	logic [5:0] curScale;

	logic       isEob;
	// One extra bit to catch a run past position 63
	logic [6:0] nextPos;
	logic [2:0] newBlk;

	assign isEob   = (i_dataIn == END_OF_BLOCK);
	assign nextPos = 7'(zagPos) + 7'(i_dataIn.acCode.run) + 7'd1;

	// Mode sampled when the header arrives
	assign newBlk  = i_yOnly ? BLK_Y_ONLY : blkCnt;

	// Held per block, so they line up with every strobe of the block
	assign o_bus.scale  = curScale;
	assign o_bus.blkNum = curBlk;

	// ------------------------------------------------------------------
	// Control and strobes
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			inAc           <= 1'b0;
			blkCnt         <= 3'd0;
			o_bus.wrt      <= 1'b0;
			o_bus.complete <= 1'b0;
		end
		else
		begin
			o_bus.wrt      <= 1'b0;
			o_bus.complete <= 1'b0;
			if (i_dataWrite)
			begin
				if (!inAc)
				begin
					// Padding before a header is skipped
					if (!isEob)
					begin
						inAc      <= 1'b1;
						o_bus.wrt <= 1'b1;
					end
				end
				else if (isEob)
				begin
					inAc           <= 1'b0;
					o_bus.complete <= 1'b1;
					// Cr, Cb, Y0..Y3 then wrap
					if (curBlk != BLK_Y_ONLY)
					begin
						blkCnt <= (blkCnt == 3'd5) ? 3'd0 : blkCnt + 3'd1;
					end
				end
				else if (!nextPos[6])
				begin
					o_bus.wrt <= 1'b1;
				end
				// A run past the end of the block is dropped
			end
		end
	end

	// ------------------------------------------------------------------
	// Coefficient fields
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (i_dataWrite && !isEob)
		begin
			if (!inAc)
			begin
				// DC header, always position 0
				zagPos       <= 6'd0;
				curScale     <= i_dataIn.dcHdr.quantScale;
				curBlk       <= newBlk;
				o_bus.isDC   <= 1'b1;
				o_bus.zagIdx <= 6'd0;
				o_bus.linIdx <= zagToLinear(6'd0);
				o_bus.level  <= i_dataIn.dcHdr.dcLevel;
			end
			else if (!nextPos[6])
			begin
				// Skip run zeros, land on the next coefficient
				zagPos       <= nextPos[5:0];
				o_bus.isDC   <= 1'b0;
				o_bus.zagIdx <= nextPos[5:0];
				o_bus.linIdx <= zagToLinear(nextPos[5:0]);
				o_bus.level  <= i_dataIn.acCode.acLevel;
			end
		end
	end

endmodule

// ==== mdecDequant.sv ====
`timescale 1ns/1ps

module mdecDequant (
	input                                      clk,
	input                                      i_rst,
	coefBus.dst                                i_bus,
	input                                      i_quantWrt,
	input        [5:0]                         i_quantAdr,
	input        [mdec_pkg::QUANT_W-1:0]       i_quantValue,
	input                                      i_quantTblSelect,
	output logic                               o_coefWrt,
	output logic [5:0]                         o_coefIdx,
	output logic signed [mdec_pkg::COEF_W-1:0] o_coefValue,
	output logic [2:0]                         o_coefBlk,
	output logic                               o_blockDone
);
	import mdec_pkg::*;

	// Product widths, scale is 6 bits
	localparam int DC_W   = LEVEL_W + QUANT_W;
	localparam int AC_W   = LEVEL_W + QUANT_W + 6;
	localparam int QSCL_W = QUANT_W + 6;

	// ------------------------------------------------------------------
	// Quantization tables, zigzag order
	// ------------------------------------------------------------------
	logic [QUANT_W-1:0] lumaTbl   [64];
	logic [QUANT_W-1:0] chromaTbl [64];

	// Select 1 loads chroma, 0 loads luma
	always_ff @(posedge clk)
	begin
		if (i_quantWrt)
		begin
			if (i_quantTblSelect)
			begin
				chromaTbl[i_quantAdr] <= i_quantValue;
			end
			else
			begin
				lumaTbl[i_quantAdr] <= i_quantValue;
			end
		end
	end

	// ------------------------------------------------------------------
	// Scale and multiply
	// ------------------------------------------------------------------
	logic                     useChroma;
	logic [QUANT_W-1:0]       qEntry;
	logic [QSCL_W-1:0]        qScaled;
	logic signed [DC_W-1:0]   dcProd;
	logic signed [AC_W-1:0]   acProd;
	logic signed [AC_W-1:0]   acShift;
	logic signed [COEF_W-1:0] coefNext;

	// Cr and Cb are blocks 0 and 1
	assign useChroma = (i_bus.blkNum[2:1] == 2'b00);

	always_comb
	begin
		// Entry 0 for DC, since a DC always sits at position 0
		qEntry  = useChroma ? chromaTbl[i_bus.zagIdx] : lumaTbl[i_bus.zagIdx];
		qScaled = QSCL_W'(qEntry) * QSCL_W'(i_bus.scale);
		// Zero-extended so the table values stay positive
		dcProd  = i_bus.level * $signed({1'b0, qEntry});
		acProd  = i_bus.level * $signed({1'b0, qScaled});
		// Floor divide by 8
		acShift = acProd >>> 3;
		if (i_bus.isDC)
		begin
			coefNext = COEF_W'(dcProd);
		end
		else
		begin
			// Fits in 20 bits, no saturation needed
			coefNext = COEF_W'(acShift);
		end
	end

	// ------------------------------------------------------------------
	// Output stage
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			o_coefWrt   <= 1'b0;
			o_blockDone <= 1'b0;
		end
		else
		begin
			o_coefWrt   <= i_bus.wrt;
			o_blockDone <= i_bus.complete;
		end
	end

	// Fields follow the strobes, meaningful only with them
	always_ff @(posedge clk)
	begin
		o_coefIdx   <= i_bus.linIdx;
		o_coefValue <= coefNext;
		o_coefBlk   <= i_bus.blkNum;
	end

endmodule

// ==== mdecFrontEnd.sv ====
`timescale 1ns/1ps

module mdecFrontEnd (
	input                                clk,
	input                                i_rst,

	// Run-length stream, one word per strobe
	input                                i_dataWrite,
	input  [15:0]                        i_dataIn,
	input                                i_yOnly,

	// Quantization table load, address in zigzag order
	input                                i_quantWrt,
	input  [5:0]                         i_quantAdr,
	input  [mdec_pkg::QUANT_W-1:0]       i_quantValue,
	input                                i_quantTblSelect,

	// Dequantized coefficients toward the IDCT
	output                               o_coefWrt,
	output [5:0]                         o_coefIdx,
	output signed [mdec_pkg::COEF_W-1:0] o_coefValue,
	output [2:0]                         o_coefBlk,
	output                               o_blockDone
);

	// ------------------------------------------------------------------
	// Decoder to dequantizer link
	// ------------------------------------------------------------------
	coefBus decBus ();

	// Stage 1, stream word to positioned level
	mdecStreamDecoder streamDecoder (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_dataWrite (i_dataWrite),
		.i_dataIn    (i_dataIn),
		.i_yOnly     (i_yOnly),
		.o_bus       (decBus.src)
	);

	// Stage 2, table lookup and scaling
	mdecDequant dequant (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_bus            (decBus.dst),
		.i_quantWrt       (i_quantWrt),
		.i_quantAdr       (i_quantAdr),
		.i_quantValue     (i_quantValue),
		.i_quantTblSelect (i_quantTblSelect),
		.o_coefWrt        (o_coefWrt),
		.o_coefIdx        (o_coefIdx),
		.o_coefValue      (o_coefValue),
		.o_coefBlk        (o_coefBlk),
		.o_blockDone      (o_blockDone)
	);

endmodule

// ==== tb_clockGen.sv ====
`timescale 1ns/1ps

module tb_clockGen (
	output logic o_clk
);

	// 10 ns period
	initial
	begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

endmodule

// ==== mdecFrontEnd_assert.sv ====
`timescale 1ns/1ps

module mdecFrontEnd_assert (
	input       clk,
	input       i_rst,
	input       i_busWrt,
	input       i_busIsDc,
	input       i_coefWrt,
	input [5:0] i_coefIdx,
	input       i_blockDone
);

	// Number of assertion failures so far
	int failCount = 0;

	// Coefficient and block done never share a cycle
	strobesExclusive: assert property (@(posedge clk) disable iff (i_rst)
		!(i_coefWrt && i_blockDone))
		else
		begin
			$error("coefficient strobe and block done high together");
			failCount++;
		end

	// Output strobes cleared one cycle after reset
	resetClears: assert property (@(posedge clk) i_rst |=> (!i_coefWrt && !i_blockDone))
		else
		begin
			$error("output strobes still high after reset");
			failCount++;
		end

	// DC always lands at linear index 0
	dcAtZero: assert property (@(posedge clk) disable iff (i_rst)
		(i_busWrt && i_busIsDc) |=> (i_coefIdx == 6'd0))
		else
		begin
			$error("DC coefficient with nonzero index");
			failCount++;
		end

endmodule

bind mdecDequant mdecFrontEnd_assert dequantChecks (
	.clk         (clk),
	.i_rst       (i_rst),
	.i_busWrt    (i_bus.wrt),
	.i_busIsDc   (i_bus.isDC),
	.i_coefWrt   (o_coefWrt),
	.i_coefIdx   (o_coefIdx),
	.i_blockDone (o_blockDone)
);

// ==== tb_mdecFrontEnd.sv ====
`timescale 1ns/1ps

module tb_mdecFrontEnd;
	import mdec_pkg::*;

	logic        clk;
	logic        i_rst;
	logic        i_dataWrite;
	logic [15:0] i_dataIn;
	logic        i_yOnly;
	logic        i_quantWrt;
	logic [5:0]  i_quantAdr;
	logic [6:0]  i_quantValue;
	logic        i_quantTblSelect;
	logic        o_coefWrt;
	logic [5:0]  o_coefIdx;
	logic signed [19:0] o_coefValue;
	logic [2:0]  o_coefBlk;
	logic        o_blockDone;

	// Expected record holds done, block[2:0], index[5:0] and value[19:0]
	logic [29:0] expQ[$];
	int          errCount = 0;
	int          passCount = 0;
	int          testErrStart = 0;
	int          deadline = 100;
	int          cycleCount = 0;

	// Model state mirroring the decoder between blocks
	logic [6:0]  refLuma [64];
	logic [6:0]  refChroma [64];
	int          zagLin [64];
	bit          refInAc = 1'b0;
	int          refPos = 0;
	int          refScale = 0;
	logic [2:0]  refBlk = 3'd0;
	logic [2:0]  refBlkCnt = 3'd0;

	tb_clockGen clockGen (.o_clk(clk));

	mdecFrontEnd i_dut (
		.clk              (clk),
		.i_rst            (i_rst),
		.i_dataWrite      (i_dataWrite),
		.i_dataIn         (i_dataIn),
		.i_yOnly          (i_yOnly),
		.i_quantWrt       (i_quantWrt),
		.i_quantAdr       (i_quantAdr),
		.i_quantValue     (i_quantValue),
		.i_quantTblSelect (i_quantTblSelect),
		.o_coefWrt        (o_coefWrt),
		.o_coefIdx        (o_coefIdx),
		.o_coefValue      (o_coefValue),
		.o_coefBlk        (o_coefBlk),
		.o_blockDone      (o_blockDone)
	);

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------
	// Walk the 15 anti-diagonals of the 8x8 block
	function automatic void buildZigzagMap();
		int n;
		int row;
		n = 0;
		for (int s = 0; s < 15; s++)
		begin
			for (int i = 0; i < 8; i++)
			begin
				// Odd diagonals go down the rows, even ones go up
				row = (s % 2 == 1) ? i : 7 - i;
				if (s - row >= 0 && s - row <= 7)
				begin
					zagLin[n] = row * 8 + (s - row);
					n++;
				end
			end
		end
	endfunction

	function automatic logic [15:0] codeWord(input int upper, input int level);
		return {upper[5:0], level[9:0]};
	endfunction

	// Cr and Cb use chroma
	function automatic int tableEntry(input logic [2:0] blk, input int zag);
		if (blk == 3'd0 || blk == 3'd1)
			return int'(refChroma[zag]);
		return int'(refLuma[zag]);
	endfunction

	function automatic void refModel(input logic [15:0] words[$], input bit yOnly);
		int level;
		int nextPos;
		int prod;
		foreach (words[k])
		begin
			level = int'($signed(words[k][9:0]));
			if (!refInAc)
			begin
				// Padding skipped while waiting for a header
				if (words[k] != END_OF_BLOCK)
				begin
					refInAc  = 1'b1;
					refPos   = 0;
					refScale = int'(words[k][15:10]);
					refBlk   = yOnly ? BLK_Y_ONLY : refBlkCnt;
					prod     = level * tableEntry(refBlk, 0);
					expQ.push_back({1'b0, refBlk, zagLin[0][5:0], prod[19:0]});
				end
			end
			else if (words[k] == END_OF_BLOCK)
			begin
				refInAc = 1'b0;
				expQ.push_back({1'b1, refBlk, 26'd0});
				if (refBlk != BLK_Y_ONLY)
					refBlkCnt = (refBlkCnt == 3'd5) ? 3'd0 : refBlkCnt + 3'd1;
			end
			else
			begin
				nextPos = refPos + int'(words[k][15:10]) + 1;
				// Word lost past position 63
				if (nextPos <= 63)
				begin
					refPos = nextPos;
					prod   = level * tableEntry(refBlk, refPos) * refScale;
					prod   = prod >>> 3;
					expQ.push_back({1'b0, refBlk, zagLin[refPos][5:0], prod[19:0]});
				end
			end
		end
	endfunction

	// Random block whose runs stay inside it and whose levels never form the end code
	function automatic void randomBlock(output logic [15:0] blk[$]);
		int pos;
		int run;
		int n;
		blk = {};
		pos = 0;
		blk.push_back(codeWord($urandom_range(63, 0), int'($urandom_range(1022, 0)) - 511));
		n = $urandom_range(20, 0);
		for (int i = 0; i < n && pos < 63; i++)
		begin
			run = $urandom_range(62 - pos, 0);
			pos += run + 1;
			blk.push_back(codeWord(run, int'($urandom_range(1022, 0)) - 511));
		end
		blk.push_back(END_OF_BLOCK);
	endfunction

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	task automatic loadTable(input bit chroma);
		logic [6:0] val;
		deadline += 70;
		for (int a = 0; a < 64; a++)
		begin
			val = 7'($urandom_range(127, 1));
			@(posedge clk);
			i_quantWrt       <= 1'b1;
			i_quantAdr       <= 6'(a);
			i_quantValue     <= val;
			i_quantTblSelect <= chroma;
			if (chroma)
				refChroma[a] = val;
			else
				refLuma[a] = val;
		end
		@(posedge clk);
		i_quantWrt <= 1'b0;
	endtask

	// Up to maxGap idle cycles after each word
	task automatic sendStream(input logic [15:0] words[$], input bit yOnly, input int maxGap);
		int gap;
		deadline += words.size() * (maxGap + 1) * 2 + 50;
		refModel(words, yOnly);
		foreach (words[k])
		begin
			@(posedge clk);
			i_dataWrite <= 1'b1;
			i_dataIn    <= words[k];
			i_yOnly     <= yOnly;
			gap = (maxGap > 0) ? $urandom_range(maxGap, 0) : 0;
			repeat (gap)
			begin
				@(posedge clk);
				i_dataWrite <= 1'b0;
			end
		end
		@(posedge clk);
		i_dataWrite <= 1'b0;
	endtask

	task automatic drainOutputs();
		int waitCycles;
		deadline += 110;
		waitCycles = 0;
		while (expQ.size() != 0 && waitCycles < 100)
		begin
			@(posedge clk);
			waitCycles++;
		end
		if (expQ.size() != 0)
		begin
			$display("Missing outputs at %0t: %0d expected results never appeared",
				$time, expQ.size());
			errCount += expQ.size();
			expQ.delete();
		end
		// Idle tail to catch stray outputs
		repeat (4) @(posedge clk);
	endtask

	task automatic finishTest(input string name);
		if (errCount == testErrStart)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, errCount - testErrStart);
		testErrStart = errCount;
	endtask

	// ------------------------------------------------------------------
	// Compare against expected queue
	// ------------------------------------------------------------------
	always @(posedge clk)
	begin
		logic [29:0] expRec;
		bit          allOk;
		if (o_coefWrt || o_blockDone)
		begin
			if (expQ.size() == 0)
			begin
				$display("Extra output at %0t: DUT gave a result that was not expected", $time);
				errCount++;
			end
			else
			begin
				expRec = expQ.pop_front();
				allOk  = 1'b1;
				if (o_blockDone != expRec[29])
				begin
					$display("CHECK FAILED at %0t: o_blockDone expected %0d got %0d",
						$time, expRec[29], o_blockDone);
					allOk = 1'b0;
				end
				else
				begin
					if (o_coefBlk != expRec[28:26])
					begin
						$display("CHECK FAILED at %0t: o_coefBlk expected %0d got %0d",
							$time, expRec[28:26], o_coefBlk);
						allOk = 1'b0;
					end
					if (!expRec[29] && o_coefIdx != expRec[25:20])
					begin
						$display("CHECK FAILED at %0t: o_coefIdx expected %0d got %0d",
							$time, expRec[25:20], o_coefIdx);
						allOk = 1'b0;
					end
					if (!expRec[29] && o_coefValue != expRec[19:0])
					begin
						$display("CHECK FAILED at %0t: o_coefValue expected %0d got %0d",
							$time, $signed(expRec[19:0]), o_coefValue);
						allOk = 1'b0;
					end
				end
				if (allOk)
					passCount++;
				else
					errCount++;
			end
		end
	end

	// Deadline grows with each stream, load and drain
	initial
	begin
		while (cycleCount < deadline)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run still going after %0d cycles", cycleCount);
		$display("Test failures found");
		$finish;
	end

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial
	begin
		logic [15:0] words[$];
		void'($urandom(56584));
		buildZigzagMap();
		i_rst            <= 1'b1;
		i_dataWrite      <= 1'b0;
		i_dataIn         <= 16'd0;
		i_yOnly          <= 1'b0;
		i_quantWrt       <= 1'b0;
		i_quantAdr       <= 6'd0;
		i_quantValue     <= 7'd0;
		i_quantTblSelect <= 1'b0;
		repeat (10) @(posedge clk);
		i_rst <= 1'b0;

		loadTable(1'b0);
		loadTable(1'b1);
		// Last AC word runs past 63 and is dropped
		words = '{codeWord(10, 50), codeWord(0, -3), codeWord(2, 7), codeWord(10, -100),
			codeWord(40, 5), codeWord(20, 3), END_OF_BLOCK};
		sendStream(words, 1'b1, 0);
		drainOutputs();
		finishTest("1 luma block in Y-only mode");

		// Cr, Cb, Y0..Y3
		for (int b = 0; b < 6; b++)
		begin
			randomBlock(words);
			sendStream(words, 1'b0, 0);
		end
		drainOutputs();
		finishTest("2 six color blocks");

		words = '{END_OF_BLOCK, END_OF_BLOCK, END_OF_BLOCK, codeWord(5, 100),
			codeWord(0, -7), END_OF_BLOCK};
		sendStream(words, 1'b0, 0);
		drainOutputs();
		finishTest("3 padding before header");

		words = '{codeWord(8, -60), codeWord(1, 25), codeWord(5, -9), END_OF_BLOCK};
		sendStream(words, 1'b1, 0);
		drainOutputs();
		loadTable(1'b0);
		sendStream(words, 1'b1, 0);
		drainOutputs();
		finishTest("4 table rewrite between blocks");

		for (int b = 0; b < 25; b++)
		begin
			randomBlock(words);
			sendStream(words, bit'($urandom_range(1, 0)), 2);
		end
		drainOutputs();
		finishTest("5 random streams");

		// Partial block followed by reset
		randomBlock(words);
		sendStream(words, 1'b0, 0);
		// Block counter away from 0 so its reset is visible
		if (refBlkCnt == 3'd0)
		begin
			randomBlock(words);
			sendStream(words, 1'b0, 0);
		end
		words = '{codeWord(9, 77), codeWord(1, -20), codeWord(0, 4)};
		sendStream(words, 1'b0, 0);
		drainOutputs();
		deadline += 10;
		@(posedge clk);
		i_rst <= 1'b1;
		repeat (3) @(posedge clk);
		i_rst <= 1'b0;
		refInAc   = 1'b0;
		refBlkCnt = 3'd0;
		// Must restart as DC header of block 0
		words = '{codeWord(12, -33), codeWord(3, 18), END_OF_BLOCK};
		sendStream(words, 1'b0, 0);
		drainOutputs();
		finishTest("6 reset mid-block");

		if (i_dut.dequant.dequantChecks.failCount != 0)
		begin
			$display("Assertion failures in the dequantizer checks: %0d",
				i_dut.dequant.dequantChecks.failCount);
			errCount += i_dut.dequant.dequantChecks.failCount;
		end

		$display("Summary: %0d outputs matched, %0d errors", passCount, errCount);
		if (errCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== mdecFrontEnd.f ====
mdec_pkg.sv
coefBus.sv
mdecStreamDecoder.sv
mdecDequant.sv
mdecFrontEnd.sv
tb_clockGen.sv
mdecFrontEnd_assert.sv
tb_mdecFrontEnd.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mdecFrontEnd \
	-f mdecFrontEnd.f -o simv \
	&& ./obj_dir/simv | tee sim.log \
	&& grep -q "All tests passed!" sim.log \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }
